/* verilog.f */
logic/adpcma_pkg.sv
logic/adpcma_decoder.sv
logic/adpcma_channel.sv
logic/rom_arbiter.sv
logic/sample_rom.sv
logic/adpcma_mixer.sv
logic/adpcma_top.sv
verif/tb_clock.sv
verif/adpcma_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= adpcma_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0 -Wno-fatal
LINTFLAGS ?= --lint-only --timing --assert
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: all run build lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* verif/sample_rom.hex */
// one sample byte per column, 16 bytes per line from address 00
// each byte holds two ADPCM-A codes, the high nibble decodes first
08 19 2a 3b 4c 5d 6e 7f 80 91 a2 b3 c4 d5 e6 f7
12 34 56 70 0f 1e 2d 3c 4b 5a 69 78 87 96 a5 b4
77 31 8c 05 f2 6a 19 b0 43 7e d1 28 94 0b 6f 52
c3 1a 57 e8 20 9d 64 0e 73 b9 2f 81 46 da 15 6c
77 77 77 77 00 00 00 00 11 11 22 22 33 33 00 00
77 77 77 76 00 01 00 10 21 12 00 00 30 03 11 00
76 77 77 77 10 00 01 00 02 20 11 11 00 00 23 32
77 67 77 77 00 00 12 21 00 00 31 13 00 00 00 00
ff ff ff ff 88 88 88 88 99 99 aa aa bb bb 88 88
ff ff ff fe 88 89 88 98 a9 9a 88 88 b8 8b 99 88
fe ff ff ff 98 88 89 88 8a a8 99 99 88 88 ab ba
ff ef ff ff 88 88 9a a9 88 88 b9 9b 88 88 88 88
4c 4c 4c 4c c4 c4 c4 c4 3b 3b b3 b3 71 f1 71 f1
70 70 07 07 f0 f0 0f 0f 25 a5 25 a5 62 e2 62 e2
7f 7f f7 f7 5d 5d d5 d5 18 81 18 81 6e e6 6e e6
77 77 70 00 07 77 00 f8 8f ff 88 80 08 f7 7f 00

/* verif/adpcma_tb.sv */
module adpcma_tb;

    localparam int num_tests = 8;
    localparam int max_cmds = 4;
    localparam int max_outs = 64;
    localparam int run_limit = 3000;
    localparam int drain_limit = 200;
    localparam int credit_rand = 0;
    localparam int credit_stall = 1;

    logic                          clk;
    logic                          rst;
    adpcma_pkg::ch_cmd_t           cmd;
    logic                          credit_return;
    logic                          out_valid;
    logic signed [15:0]            out_sample;
    logic [adpcma_pkg::num_ch-1:0] busy;

    // the test table holds one row per entry and one column per command
    string                t_name [num_tests];
    int                   t_mode [num_tests];
    int                   t_nout [num_tests];
    int                   t_ncmd [num_tests];
    adpcma_pkg::cmd_op_t  c_op [num_tests][max_cmds];
    int                   c_ch [num_tests][max_cmds];
    int                   c_first [num_tests][max_cmds];
    int                   c_last [num_tests][max_cmds];
    int                   c_at [num_tests][max_cmds];
    int                   n_tests;

    logic [7:0] rom [256];
    int         ch_pcm [adpcma_pkg::num_ch][512];
    int         exp_q [max_outs];
    int         due_q [$];
    int         last_due;
    bit         released;
    int         cyc;
    int         n_out;
    int         checks;
    int         errors;
    int         timeouts;

    int step_tab [49] = '{
        16, 17, 19, 21, 23, 25, 28, 31, 34, 37, 41, 45, 50, 55, 60, 66, 73,
        80, 88, 97, 107, 118, 130, 143, 157, 173, 190, 209, 230, 253, 279, 307, 337,
        371, 408, 449, 494, 544, 598, 658, 724, 796, 876, 963, 1060, 1166, 1282, 1411, 1552
    };

    tb_clock clk_i (
        .clk (clk)
    );

    adpcma_top dut_i (
        .clk           (clk),
        .rst           (rst),
        .cmd           (cmd),
        .credit_return (credit_return),
        .out_valid     (out_valid),
        .out_sample    (out_sample),
        .busy          (busy)
    );

    task automatic add_test(input string name, input int mode, input int nout);
        t_name[n_tests] = name;
        t_mode[n_tests] = mode;
        t_nout[n_tests] = nout;
        t_ncmd[n_tests] = 0;
        n_tests++;
    endtask

    task automatic append_cmd(input adpcma_pkg::cmd_op_t op, input int ch, input int first,
                              input int last, input int at);
        int t;
        int k;
        t = n_tests - 1;
        k = t_ncmd[t];
        c_op[t][k] = op;
        c_ch[t][k] = ch;
        c_first[t][k] = first;
        c_last[t][k] = last;
        c_at[t][k] = at;
        t_ncmd[t] = k + 1;
    endtask

    // key-ons go out on consecutive cycles, a key-off once its output count is reached
    task automatic load_table();
        add_test("reset_idle", credit_rand, 0);
        add_test("single_ch", credit_rand, 32);
        append_cmd(adpcma_pkg::cmd_key_on, 0, 'h00, 'h0f, 0);
        add_test("four_ch_sat_pos", credit_rand, 32);
        append_cmd(adpcma_pkg::cmd_key_on, 0, 'h40, 'h4f, 0);
        append_cmd(adpcma_pkg::cmd_key_on, 1, 'h50, 'h5f, 0);
        append_cmd(adpcma_pkg::cmd_key_on, 2, 'h60, 'h6f, 0);
        append_cmd(adpcma_pkg::cmd_key_on, 3, 'h70, 'h77, 0);
        add_test("four_ch_sat_neg", credit_rand, 32);
        append_cmd(adpcma_pkg::cmd_key_on, 0, 'h80, 'h8f, 0);
        append_cmd(adpcma_pkg::cmd_key_on, 1, 'h90, 'h9f, 0);
        append_cmd(adpcma_pkg::cmd_key_on, 2, 'ha0, 'ha7, 0);
        append_cmd(adpcma_pkg::cmd_key_on, 3, 'hb0, 'hbf, 0);
        add_test("four_ch_mixed", credit_rand, 32);
        append_cmd(adpcma_pkg::cmd_key_on, 3, 'he0, 'he3, 0);
        append_cmd(adpcma_pkg::cmd_key_on, 2, 'hc0, 'hcb, 0);
        append_cmd(adpcma_pkg::cmd_key_on, 1, 'h10, 'h1f, 0);
        append_cmd(adpcma_pkg::cmd_key_on, 0, 'h00, 'h07, 0);
        add_test("key_off_mid", credit_rand, 32);
        append_cmd(adpcma_pkg::cmd_key_on, 0, 'h20, 'h2f, 0);
        append_cmd(adpcma_pkg::cmd_key_on, 1, 'h30, 'h3f, 0);
        append_cmd(adpcma_pkg::cmd_key_on, 2, 'hd0, 'hdf, 0);
        append_cmd(adpcma_pkg::cmd_key_off, 1, 0, 0, 9);
        add_test("credit_stall", credit_stall, 32);
        append_cmd(adpcma_pkg::cmd_key_on, 0, 'hf0, 'hff, 0);
        append_cmd(adpcma_pkg::cmd_key_on, 1, 'h40, 'h47, 0);
        add_test("single_ch_again", credit_rand, 32);
        append_cmd(adpcma_pkg::cmd_key_on, 3, 'hf0, 'hff, 0);
    endtask

    task automatic decode_code(input int code, inout int acc, inout int idx);
        int mag;
        int inc;
        mag = code % 8;
        inc = step_tab[idx] * (2 * mag + 1) / 8;
        acc = (code >= 8) ? acc - inc : acc + inc;
        acc = int'(shortint'(acc));
        if (mag < 4) begin
            idx = (idx == 0) ? 0 : idx - 1;
        end else begin
            case (mag)
                4: idx = idx + 2;
                5: idx = idx + 5;
                6: idx = idx + 7;
                default: idx = idx + 9;
            endcase
            if (idx > adpcma_pkg::max_step) idx = adpcma_pkg::max_step;
        end
    endtask

    // channels advance in lockstep, one code per output, until their range ends or key-off
    task automatic build_expected(input int t);
        int limit [adpcma_pkg::num_ch];
        int acc;
        int idx;
        int c;
        int n;
        int sum;
        for (int i = 0; i < adpcma_pkg::num_ch; i++) limit[i] = 0;
        for (int k = 0; k < t_ncmd[t]; k++) begin
            c = c_ch[t][k];
            if (c_op[t][k] == adpcma_pkg::cmd_key_on) begin
                acc = 0;
                idx = 0;
                n = 0;
                for (int a = c_first[t][k]; a <= c_last[t][k]; a++) begin
                    decode_code(int'(rom[a][7:4]), acc, idx);
                    ch_pcm[c][n] = acc;
                    decode_code(int'(rom[a][3:0]), acc, idx);
                    ch_pcm[c][n + 1] = acc;
                    n = n + 2;
                end
                limit[c] = n;
            end else if (c_at[t][k] < limit[c]) begin
                limit[c] = c_at[t][k];
            end
        end
        for (int j = 0; j < t_nout[t]; j++) begin
            sum = 0;
            for (int i = 0; i < adpcma_pkg::num_ch; i++) begin
                if (j < limit[i]) sum = sum + ch_pcm[i][j];
            end
            if (sum > 32767) sum = 32767;
            else if (sum < -32768) sum = -32768;
            exp_q[j] = sum;
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
        cyc++;
        cmd = '0;
        credit_return = 1'b0;
        if (released && due_q.size() > 0 && due_q[0] <= cyc) begin
            credit_return = 1'b1;
            void'(due_q.pop_front());
        end
    endtask

    task automatic observe_output(input int t);
        int got;
        int due;
        if (out_valid) begin
            got = out_sample;
            checks++;
            assert (n_out < t_nout[t]) else begin
                errors++;
                $display("%s: an output arrived after all %0d were collected",
                         t_name[t], t_nout[t]);
            end
            if (n_out < t_nout[t]) begin
                checks++;
                assert (got == exp_q[n_out]) else begin
                    errors++;
                    $display("error %s out[%0d]: expected %0d actual %0d",
                             t_name[t], n_out, exp_q[n_out], got);
                end
            end
            n_out++;
            due = cyc + 1 + int'($urandom % 5);
            if (due <= last_due) due = last_due + 1;
            last_due = due;
            due_q.push_back(due);
        end
    endtask

    task automatic run_test(input int t);
        int k;
        int stall_left;
        int wait_cnt;
        build_expected(t);
        n_out = 0;
        k = 0;
        stall_left = 30;
        wait_cnt = 0;
        released = (t_mode[t] != credit_stall);
        while ((n_out < t_nout[t] || k < t_ncmd[t]) && wait_cnt < run_limit) begin
            next_cycle();
            wait_cnt++;
            observe_output(t);
            if (!released) begin
                checks++;
                assert (n_out <= adpcma_pkg::mix_credits) else begin
                    errors++;
                    $display("%s: more outputs were sent than credits allow", t_name[t]);
                    released = 1'b1;
                end
                if (n_out == adpcma_pkg::mix_credits) stall_left--;
                if (stall_left == 0) released = 1'b1;
            end
            if (k < t_ncmd[t] && n_out >= c_at[t][k]) begin
                cmd.op = c_op[t][k];
                cmd.ch = 2'(c_ch[t][k]);
                cmd.start_addr = 8'(c_first[t][k]);
                cmd.end_addr = 8'(c_last[t][k]);
                k++;
            end
        end
        if (wait_cnt >= run_limit) begin
            timeouts++;
            $display("timeout in %s: %0d of %0d outputs arrived", t_name[t], n_out, t_nout[t]);
        end
        // all channels must fall idle and every owed credit go back
        released = 1'b1;
        wait_cnt = 0;
        while ((busy != '0 || due_q.size() != 0) && wait_cnt < drain_limit) begin
            next_cycle();
            wait_cnt++;
            observe_output(t);
        end
        if (wait_cnt >= drain_limit) begin
            timeouts++;
            $display("timeout in %s: channels never went idle", t_name[t]);
        end
        repeat (10) begin
            next_cycle();
            checks++;
            assert (!out_valid && busy == '0) else begin
                errors++;
                $display("%s: output or busy seen while the player should be idle", t_name[t]);
            end
        end
    endtask

    initial begin
        void'($urandom(61335));
        rst = 1'b1;
        cmd = '0;
        credit_return = 1'b0;
        checks = 0;
        errors = 0;
        timeouts = 0;
        cyc = 0;
        last_due = 0;
        n_tests = 0;
        released = 1'b1;
        $readmemh("verif/sample_rom.hex", rom);
        load_table();
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        checks++;
        assert (!out_valid && busy == '0) else begin
            errors++;
            $display("out_valid or busy is high right after reset");
        end
        for (int t = 0; t < n_tests && timeouts == 0; t++) begin
            run_test(t);
        end
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* verif/tb_clock.sv */
module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

endmodule

/* logic/adpcma_top.sv */
module adpcma_top (
    input  logic                          clk,
    input  logic                          rst,
    input  adpcma_pkg::ch_cmd_t           cmd,
    input  logic                          credit_return,
    output logic                          out_valid,
    output logic signed [15:0]            out_sample,
    output logic [adpcma_pkg::num_ch-1:0] busy
);

    adpcma_pkg::rom_req_t          reqs [adpcma_pkg::num_ch];
    adpcma_pkg::rom_rsp_t          rom_rsp;
    logic [adpcma_pkg::num_ch-1:0] grant;
    logic [adpcma_pkg::num_ch-1:0] sample_valid;
    logic signed [15:0]            pcm [adpcma_pkg::num_ch];
    logic [adpcma_pkg::rom_aw-1:0] rom_addr;
    logic [7:0]                    rom_data;
    logic                          mix_take;

    for (genvar i = 0; i < adpcma_pkg::num_ch; i++) begin : g_ch
        adpcma_channel #(.ch_idx(i)) ch_i (
            .clk          (clk),
            .rst          (rst),
            .cmd          (cmd),
            .rom_req      (reqs[i]),
            .grant        (grant[i]),
            .rom_rsp      (rom_rsp),
            .sample_valid (sample_valid[i]),
            .pcm          (pcm[i]),
            .mix_take     (mix_take),
            .busy         (busy[i])
        );
    end

    rom_arbiter arb_i (
        .clk      (clk),
        .rst      (rst),
        .reqs     (reqs),
        .grant    (grant),
        .rom_addr (rom_addr),
        .rom_data (rom_data),
        .rom_rsp  (rom_rsp)
    );

    sample_rom rom_i (
        .clk  (clk),
        .addr (rom_addr),
        .data (rom_data)
    );

    adpcma_mixer mix_i (
        .clk           (clk),
        .rst           (rst),
        .busy          (busy),
        .sample_valid  (sample_valid),
        .pcm           (pcm),
        .mix_take      (mix_take),
        .credit_return (credit_return),
        .out_valid     (out_valid),
        .out_sample    (out_sample)
    );

endmodule

/* logic/adpcma_mixer.sv */
module adpcma_mixer (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [adpcma_pkg::num_ch-1:0] busy,
    input  logic [adpcma_pkg::num_ch-1:0] sample_valid,
    input  logic signed [15:0]            pcm [adpcma_pkg::num_ch],
    output logic                          mix_take,
    input  logic                          credit_return,
    output logic                          out_valid,
    output logic signed [15:0]            out_sample
);

    logic [$clog2(adpcma_pkg::mix_credits + 1)-1:0] credits;
    logic signed [17:0]                              sum;
    logic signed [15:0]                              sat;
    logic                                            send;

    always_comb begin
        sum = '0;
        for (int i = 0; i < adpcma_pkg::num_ch; i++) begin
            if (busy[i]) begin
                sum = sum + 18'(pcm[i]);
            end
        end
        if (sum > 18'sd32767) begin
            sat = 16'sh7fff;
        end else if (sum < -18'sd32768) begin
            sat = 16'sh8000;
        end else begin
            sat = sum[15:0];
        end
    end

    // channels still show their old sample while the take is in flight
    assign send = (|busy) && ((sample_valid & busy) == busy) && (credits != '0) && !out_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= adpcma_pkg::mix_credits[$bits(credits)-1:0];
            out_valid <= 1'b0;
        end else begin
            out_valid <= send;
            case ({send, credit_return})
                2'b10: credits <= credits - 1'b1;
                2'b01: credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
        if (send) begin
            out_sample <= sat;
        end
    end

    assign mix_take = out_valid;

endmodule

/* logic/sample_rom.sv */
module sample_rom (
    input  logic                          clk,
    input  logic [adpcma_pkg::rom_aw-1:0] addr,
    output logic [7:0]                    data
);

    logic [7:0] mem [2**adpcma_pkg::rom_aw];

    initial begin
        $readmemh("verif/sample_rom.hex", mem);
    end

    always_ff @(posedge clk) begin
        data <= mem[addr];
    end

endmodule

/* logic/rom_arbiter.sv */
module rom_arbiter (
    input  logic                          clk,
    input  logic                          rst,
    input  adpcma_pkg::rom_req_t          reqs [adpcma_pkg::num_ch],
    output logic [adpcma_pkg::num_ch-1:0] grant,
    output logic [adpcma_pkg::rom_aw-1:0] rom_addr,
    input  logic [7:0]                    rom_data,
    output adpcma_pkg::rom_rsp_t          rom_rsp
);

    logic [$clog2(adpcma_pkg::num_ch)-1:0] ptr;
    logic [$clog2(adpcma_pkg::num_ch)-1:0] sel;
    logic [$clog2(adpcma_pkg::num_ch)-1:0] rsp_ch;
    logic                                  found;
    logic                                  rsp_valid;

    // search starts one past the last grant
    always_comb begin
        logic [$clog2(adpcma_pkg::num_ch)-1:0] idx;
        idx = ptr;
        sel = ptr;
        found = 1'b0;
        grant = '0;
        for (int i = 0; i < adpcma_pkg::num_ch; i++) begin
            idx = idx + 1'b1;
            if (!found && reqs[idx].valid) begin
                found = 1'b1;
                sel = idx;
            end
        end
        if (found) begin
            grant[sel] = 1'b1;
        end
    end

    assign rom_addr = reqs[sel].addr;

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr <= '1;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= found;
            if (found) begin
                ptr <= sel;
            end
        end
        rsp_ch <= sel;
    end

    assign rom_rsp = '{valid: rsp_valid, ch: rsp_ch, data: rom_data};

endmodule

/* logic/adpcma_channel.sv */
module adpcma_channel #(
    parameter int unsigned ch_idx = 0
) (
    input  logic                  clk,
    input  logic                  rst,
    input  adpcma_pkg::ch_cmd_t   cmd,
    output adpcma_pkg::rom_req_t  rom_req,
    input  logic                  grant,
    input  adpcma_pkg::rom_rsp_t  rom_rsp,
    output logic                  sample_valid,
    output logic signed [15:0]    pcm,
    input  logic                  mix_take,
    output logic                  busy
);

    adpcma_pkg::ch_state_t         state;
    logic [adpcma_pkg::rom_aw-1:0] addr;
    logic [adpcma_pkg::rom_aw-1:0] end_addr;
    logic [7:0]                    data_byte;
    logic                          lo_phase;
    logic                          cmd_hit;
    logic                          key_on;
    logic                          key_off;
    logic                          rsp_hit;
    logic                          code_valid;
    logic [3:0]                    code;

    assign cmd_hit = (32'(cmd.ch) == ch_idx);
    assign key_on = cmd_hit && (cmd.op == adpcma_pkg::cmd_key_on);
    assign key_off = cmd_hit && (cmd.op == adpcma_pkg::cmd_key_off);
    assign rsp_hit = rom_rsp.valid && (32'(rom_rsp.ch) == ch_idx);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= adpcma_pkg::ch_idle;
            lo_phase <= 1'b0;
        end else if (key_on) begin
            state <= adpcma_pkg::ch_fetch;
            lo_phase <= 1'b0;
        end else if (key_off) begin
            state <= adpcma_pkg::ch_idle;
        end else begin
            case (state)
                adpcma_pkg::ch_fetch: if (grant) state <= adpcma_pkg::ch_wait;
                adpcma_pkg::ch_wait: if (rsp_hit) state <= adpcma_pkg::ch_code_hi;
                adpcma_pkg::ch_code_hi: begin
                    state <= adpcma_pkg::ch_hold;
                    lo_phase <= 1'b0;
                end
                adpcma_pkg::ch_code_lo: begin
                    state <= adpcma_pkg::ch_hold;
                    lo_phase <= 1'b1;
                end
                adpcma_pkg::ch_hold: begin
                    // after the low code the byte is used up
                    if (mix_take && !lo_phase) begin
                        state <= adpcma_pkg::ch_code_lo;
                    end else if (mix_take && addr == end_addr) begin
                        state <= adpcma_pkg::ch_idle;
                    end else if (mix_take) begin
                        state <= adpcma_pkg::ch_fetch;
                    end
                end
                default: state <= adpcma_pkg::ch_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (key_on) begin
            addr <= cmd.start_addr;
            end_addr <= cmd.end_addr;
        end else if (state == adpcma_pkg::ch_hold && mix_take && lo_phase) begin
            addr <= addr + 1'b1;
        end
        if (state == adpcma_pkg::ch_wait && rsp_hit) begin
            data_byte <= rom_rsp.data;
        end
    end

    assign code_valid = (state == adpcma_pkg::ch_code_hi) || (state == adpcma_pkg::ch_code_lo);
    assign code = (state == adpcma_pkg::ch_code_hi) ? data_byte[7:4] : data_byte[3:0];

    assign rom_req = '{valid: (state == adpcma_pkg::ch_fetch), addr: addr};
    assign sample_valid = (state == adpcma_pkg::ch_hold);
    assign busy = (state != adpcma_pkg::ch_idle);

    adpcma_decoder dec_i (
        .clk        (clk),
        .rst        (rst),
        .clear      (key_on),
        .code_valid (code_valid),
        .code       (code),
        .pcm        (pcm)
    );

endmodule

/* logic/adpcma_decoder.sv */
module adpcma_decoder (
    input  logic               clk,
    input  logic               rst,
    input  logic               clear,
    input  logic               code_valid,
    input  logic [3:0]         code,
    output logic signed [15:0] pcm
);

    logic [5:0]         step_idx;
    logic [5:0]         raised;
    logic [5:0]         step_next;
    logic [10:0]        step;
    logic [14:0]        prod;
    logic [11:0]        inc;
    logic signed [15:0] acc;

    assign step = adpcma_pkg::step_size(step_idx);

    // increment is step * (2m + 1) / 8
    assign prod = 15'(step) * 15'({code[2:0], 1'b1});
    assign inc = prod[14:3];

    always_comb begin
        case (code[2:0])
            3'd4: raised = step_idx + 6'd2;
            3'd5: raised = step_idx + 6'd5;
            3'd6: raised = step_idx + 6'd7;
            3'd7: raised = step_idx + 6'd9;
            default: raised = (step_idx == 6'd0) ? 6'd0 : step_idx - 6'd1;
        endcase
        step_next = (raised > 6'(adpcma_pkg::max_step)) ? 6'(adpcma_pkg::max_step) : raised;
    end

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            step_idx <= 6'd0;
            acc <= 16'sd0;
        end else if (code_valid) begin
            step_idx <= step_next;
            // the accumulator wraps at 16 bits
            if (code[3]) begin
                acc <= acc - 16'(inc);
            end else begin
                acc <= acc + 16'(inc);
            end
        end
    end

    assign pcm = acc;

endmodule

/* logic/adpcma_pkg.sv */
package adpcma_pkg;

    localparam int num_ch = 4;
    localparam int rom_aw = 8;
    localparam int max_step = 48;
    localparam int mix_credits = 4;

    // the standard ADPCM-A step size for each step index
    localparam logic [10:0] step_table [0:48] = '{
        11'd16, 11'd17, 11'd19, 11'd21, 11'd23, 11'd25, 11'd28,
        11'd31, 11'd34, 11'd37, 11'd41, 11'd45, 11'd50, 11'd55,
        11'd60, 11'd66, 11'd73, 11'd80, 11'd88, 11'd97, 11'd107,
        11'd118, 11'd130, 11'd143, 11'd157, 11'd173, 11'd190, 11'd209,
        11'd230, 11'd253, 11'd279, 11'd307, 11'd337, 11'd371, 11'd408,
        11'd449, 11'd494, 11'd544, 11'd598, 11'd658, 11'd724, 11'd796,
        11'd876, 11'd963, 11'd1060, 11'd1166, 11'd1282, 11'd1411, 11'd1552
    };

    typedef enum logic [1:0] {
        cmd_nop,
        cmd_key_on,
        cmd_key_off
    } cmd_op_t;

    typedef enum logic [2:0] {
        ch_idle,
        ch_fetch,
        ch_wait,
        ch_code_hi,
        ch_code_lo,
        ch_hold
    } ch_state_t;

    typedef struct packed {
        cmd_op_t                     op;
        logic [$clog2(num_ch)-1:0]   ch;
        logic [rom_aw-1:0]           start_addr;
        logic [rom_aw-1:0]           end_addr;
    } ch_cmd_t;

    typedef struct packed {
        logic                        valid;
        logic [rom_aw-1:0]           addr;
    } rom_req_t;

    typedef struct packed {
        logic                        valid;
        logic [$clog2(num_ch)-1:0]   ch;
        logic [7:0]                  data;
    } rom_rsp_t;

    // indices past the top of the table read the last entry
    function automatic logic [10:0] step_size(input logic [5:0] idx);
        if (idx > 6'(max_step)) begin
            return step_table[max_step];
        end
        return step_table[idx];
    endfunction

endpackage
